//--- verilog/trace_pkg.sv
package trace_pkg;

  // Datapath width of the traced cores
  localparam int XLEN = 32;

  // Instruction word width
  localparam int INSN_W = 32;

  // Register file index width
  localparam int REG_ADDR_W = 5;

  // Register that carries putc characters and exit codes
  localparam logic [REG_ADDR_W-1:0] REG_RET = REG_ADDR_W'(3);

  // One record per retired instruction, as delivered by each core.
  // Fields other than valid are only meaningful while valid is high
  typedef struct packed {
    logic                  valid;
    logic [XLEN-1:0]       pc;
    logic [INSN_W-1:0]     insn;
    logic                  wben;
    logic [REG_ADDR_W-1:0] wbreg;
    logic [XLEN-1:0]       wbdata;
  } trace_rec_t;

endpackage : trace_pkg

//--- verilog/mon_pkg.sv
package mon_pkg;

  // Number of monitored cores
  localparam int NUM_CORES = 4;

  // Width of a core id
  localparam int CORE_ID_W = 2;

  // Console character width
  localparam int CHAR_W = 8;

  // Special l.nop encodings used as simulation hooks
  localparam logic [trace_pkg::INSN_W-1:0] INSN_NOP_EXIT = 32'h1500_0001;
  localparam logic [trace_pkg::INSN_W-1:0] INSN_NOP_PUTC = 32'h1500_0004;

  // Entries per core in each merge queue
  localparam int QUEUE_DEPTH = 4;

  // Queue pointer and fill counter widths
  localparam int QPTR_W = $clog2(QUEUE_DEPTH);
  localparam int QCNT_W = $clog2(QUEUE_DEPTH + 1);

  // Console character from one core
  typedef struct packed {
    logic [CORE_ID_W-1:0] core_id;
    logic [CHAR_W-1:0]    ch;
  } char_evt_t;

  // Exit code from one core
  typedef struct packed {
    logic [CORE_ID_W-1:0]       core_id;
    logic [trace_pkg::XLEN-1:0] code;
  } exit_evt_t;

endpackage : mon_pkg

//--- verilog/core_trace_monitor.sv
`timescale 1ns/1ps

module core_trace_monitor (
  input  logic                          clk,
  input  logic                          rst_i,
  input  logic [mon_pkg::CORE_ID_W-1:0] core_id_i,
  input  trace_pkg::trace_rec_t         trace_i,
  output logic                          putc_stb_o,
  output mon_pkg::char_evt_t            putc_o,
  output logic                          exit_stb_o,
  output mon_pkg::exit_evt_t            exit_o,
  output logic                          done_o
);

  import trace_pkg::*;
  import mon_pkg::*;

  logic [XLEN-1:0] r3_q;
  logic            done_q;
  logic            rec_live;
  logic            is_putc;
  logic            is_exit;
  logic            r3_wr;

  // A terminated core is silent until reset
  assign rec_live = trace_i.valid && !done_q;

  // Special no-op decode
  assign is_putc = rec_live && (trace_i.insn == INSN_NOP_PUTC);
  assign is_exit = rec_live && (trace_i.insn == INSN_NOP_EXIT);

  // Writeback hitting the watched register
  assign r3_wr = rec_live && trace_i.wben && (trace_i.wbreg == REG_RET);

  // Shadow copy of r3
  always_ff @(posedge clk) begin
    if (rst_i) begin
      r3_q <= '0;
    end else if (r3_wr) begin
      r3_q <= trace_i.wbdata;
    end
  end

  // Events sample r3 before the current record's own writeback
  always_ff @(posedge clk) begin
    if (rst_i) begin
      putc_stb_o <= 1'b0;
      putc_o     <= '0;
      exit_stb_o <= 1'b0;
      exit_o     <= '0;
      done_q     <= 1'b0;
    end else begin
      putc_stb_o <= is_putc;
      exit_stb_o <= is_exit;
      if (is_putc) begin
        putc_o.core_id <= core_id_i;
        putc_o.ch      <= r3_q[CHAR_W-1:0];
      end
      if (is_exit) begin
        exit_o.core_id <= core_id_i;
        exit_o.code    <= r3_q;
        done_q         <= 1'b1;
      end
    end
  end

  assign done_o = done_q;

  // Once terminated, nothing more leaves this core
  a_quiet_after_done: assert property (
    @(posedge clk) disable iff (rst_i)
    done_o |=> !(putc_stb_o || exit_stb_o)
  );

endmodule : core_trace_monitor

//--- verilog/event_merge.sv
`timescale 1ns/1ps

module event_merge #(
  parameter type payload_t = mon_pkg::char_evt_t
) (
  input  logic                              clk,
  input  logic                              rst_i,
  input  logic [mon_pkg::NUM_CORES-1:0]     in_stb_i,
  input  payload_t [mon_pkg::NUM_CORES-1:0] in_i,
  output logic                              out_stb_o,
  output payload_t                          out_o,
  output logic                              overflow_o
);

  import mon_pkg::*;

  payload_t             mem_q    [NUM_CORES][QUEUE_DEPTH];
  logic [QPTR_W-1:0]    wr_ptr_q [NUM_CORES];
  logic [QPTR_W-1:0]    rd_ptr_q [NUM_CORES];
  logic [QCNT_W-1:0]    count_q  [NUM_CORES];
  logic [NUM_CORES-1:0] pending;
  logic [NUM_CORES-1:0] push;
  logic [NUM_CORES-1:0] pop;
  logic [NUM_CORES-1:0] drop;
  logic [CORE_ID_W-1:0] rr_last_q;
  logic [CORE_ID_W-1:0] sel;
  logic                 sel_valid;
  logic                 overflow_q;

  function automatic logic [QPTR_W-1:0] ptr_inc(input logic [QPTR_W-1:0] ptr);
    return (ptr == QPTR_W'(QUEUE_DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  // Queue status; a full queue drops the incoming event
  always_comb begin
    for (int k = 0; k < NUM_CORES; k++) begin
      pending[k] = (count_q[k] != '0);
      push[k]    = in_stb_i[k] && (count_q[k] != QCNT_W'(QUEUE_DEPTH));
      drop[k]    = in_stb_i[k] && !push[k];
    end
  end

  // Round-robin search starting just after the last served core
  always_comb begin
    int cand;
    sel       = rr_last_q;
    sel_valid = 1'b0;
    cand      = 0;
    for (int off = 1; off <= NUM_CORES; off++) begin
      cand = (int'(rr_last_q) + off) % NUM_CORES;
      if (!sel_valid && pending[cand]) begin
        sel       = CORE_ID_W'(cand);
        sel_valid = 1'b1;
      end
    end
    for (int k = 0; k < NUM_CORES; k++) begin
      pop[k] = sel_valid && (sel == CORE_ID_W'(k));
    end
  end

  // Queue storage
  always_ff @(posedge clk) begin
    for (int k = 0; k < NUM_CORES; k++) begin
      if (push[k]) begin
        mem_q[k][wr_ptr_q[k]] <= in_i[k];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst_i) begin
      for (int k = 0; k < NUM_CORES; k++) begin
        wr_ptr_q[k] <= '0;
        rd_ptr_q[k] <= '0;
        count_q[k]  <= '0;
      end
      // Core 0 gets the first turn
      rr_last_q  <= CORE_ID_W'(NUM_CORES - 1);
      out_stb_o  <= 1'b0;
      out_o      <= '0;
      overflow_q <= 1'b0;
    end else begin
      for (int k = 0; k < NUM_CORES; k++) begin
        if (push[k]) begin
          wr_ptr_q[k] <= ptr_inc(wr_ptr_q[k]);
        end
        if (pop[k]) begin
          rd_ptr_q[k] <= ptr_inc(rd_ptr_q[k]);
        end
        count_q[k] <= count_q[k] + QCNT_W'(push[k]) - QCNT_W'(pop[k]);
      end
      out_stb_o <= sel_valid;
      if (sel_valid) begin
        out_o     <= mem_q[sel][rd_ptr_q[sel]];
        rr_last_q <= sel;
      end
      if (|drop) begin
        overflow_q <= 1'b1;
      end
    end
  end

  assign overflow_o = overflow_q;

  // Every output event was stored in some queue one cycle earlier
  a_out_from_queue: assert property (
    @(posedge clk) disable iff (rst_i)
    out_stb_o |-> $past(|pending)
  );

endmodule : event_merge

//--- verilog/done_tracker.sv
`timescale 1ns/1ps

module done_tracker (
  input  logic                                        clk,
  input  logic                                        rst_i,
  input  logic [mon_pkg::NUM_CORES-1:0]               done_i,
  input  logic [mon_pkg::NUM_CORES-1:0]               exit_stb_i,
  input  mon_pkg::exit_evt_t [mon_pkg::NUM_CORES-1:0] exit_i,
  output logic                                        all_done_o,
  output logic                                        fail_o
);

  import mon_pkg::*;

  logic [NUM_CORES-1:0] bad_exit;
  logic                 all_done_q;
  logic                 fail_q;

  // Nonzero exit code on any lane
  always_comb begin
    for (int k = 0; k < NUM_CORES; k++) begin
      bad_exit[k] = exit_stb_i[k] && (exit_i[k].code != '0);
    end
  end

  always_ff @(posedge clk) begin
    if (rst_i) begin
      all_done_q <= 1'b0;
      fail_q     <= 1'b0;
    end else begin
      // Done levels are sticky in the monitors
      all_done_q <= &done_i;
      if (|bad_exit) begin
        fail_q <= 1'b1;
      end
    end
  end

  assign all_done_o = all_done_q;
  assign fail_o     = fail_q;

  // Relies on every monitor holding done until reset
  a_all_done_sticky: assert property (
    @(posedge clk) disable iff (rst_i)
    all_done_o |=> all_done_o
  );

  // Lane k carries events from core k only
  for (genvar k = 0; k < NUM_CORES; k++) begin : gen_lane_chk
    a_lane_id: assert property (
      @(posedge clk) disable iff (rst_i)
      exit_stb_i[k] |-> (exit_i[k].core_id == CORE_ID_W'(k))
    );
  end

endmodule : done_tracker

//--- verilog/trace_hub.sv
`timescale 1ns/1ps

module trace_hub (
  input  logic                                           clk,
  input  logic                                           rst_i,
  input  trace_pkg::trace_rec_t [mon_pkg::NUM_CORES-1:0] trace_i,
  output logic                                           putc_valid_o,
  output mon_pkg::char_evt_t                             putc_o,
  output logic                                           exit_valid_o,
  output mon_pkg::exit_evt_t                             exit_o,
  output logic                                           all_done_o,
  output logic                                           fail_o,
  output logic                                           overflow_o
);

  import mon_pkg::*;

  logic [NUM_CORES-1:0]      putc_stb;
  char_evt_t [NUM_CORES-1:0] putc_evt;
  logic [NUM_CORES-1:0]      exit_stb;
  exit_evt_t [NUM_CORES-1:0] exit_evt;
  logic [NUM_CORES-1:0]      core_done;
  logic                      putc_ovf;
  logic                      exit_ovf;

  // One monitor per core, id tied by position
  for (genvar k = 0; k < NUM_CORES; k++) begin : gen_core
    core_trace_monitor u_monitor (
      .clk        (clk),
      .rst_i      (rst_i),
      .core_id_i  (CORE_ID_W'(k)),
      .trace_i    (trace_i[k]),
      .putc_stb_o (putc_stb[k]),
      .putc_o     (putc_evt[k]),
      .exit_stb_o (exit_stb[k]),
      .exit_o     (exit_evt[k]),
      .done_o     (core_done[k])
    );
  end

  event_merge #(
    .payload_t (char_evt_t)
  ) u_putc_merge (
    .clk        (clk),
    .rst_i      (rst_i),
    .in_stb_i   (putc_stb),
    .in_i       (putc_evt),
    .out_stb_o  (putc_valid_o),
    .out_o      (putc_o),
    .overflow_o (putc_ovf)
  );

  event_merge #(
    .payload_t (exit_evt_t)
  ) u_exit_merge (
    .clk        (clk),
    .rst_i      (rst_i),
    .in_stb_i   (exit_stb),
    .in_i       (exit_evt),
    .out_stb_o  (exit_valid_o),
    .out_o      (exit_o),
    .overflow_o (exit_ovf)
  );

  done_tracker u_done_tracker (
    .clk        (clk),
    .rst_i      (rst_i),
    .done_i     (core_done),
    .exit_stb_i (exit_stb),
    .exit_i     (exit_evt),
    .all_done_o (all_done_o),
    .fail_o     (fail_o)
  );

  assign overflow_o = putc_ovf | exit_ovf;

endmodule : trace_hub

//--- sim/trace_model.svh
`ifndef TRACE_MODEL_SVH
`define TRACE_MODEL_SVH

// Special no-op encodings as the cores issue them
localparam logic [31:0] MODEL_NOP_EXIT = 32'h1500_0001;
localparam logic [31:0] MODEL_NOP_PUTC = 32'h1500_0004;
localparam logic [4:0]  MODEL_RET_REG  = 5'd3;

logic [31:0] model_r3   [NUM_CORES];
bit          model_done [NUM_CORES];
bit          model_fail;

// Events still owed by the DUT, oldest first
logic [7:0]  exp_ch   [NUM_CORES][$];
logic [31:0] exp_code [NUM_CORES][$];

function automatic void model_reset();
  for (int k = 0; k < NUM_CORES; k++) begin
    model_r3[k]   = '0;
    model_done[k] = 1'b0;
    exp_ch[k].delete();
    exp_code[k].delete();
  end
  model_fail = 1'b0;
endfunction

// Events see r3 as it was before this record's own writeback
function automatic void model_apply(input int k, input trace_rec_t rec);
  if (!rec.valid || model_done[k]) begin
    return;
  end
  if (rec.insn == MODEL_NOP_PUTC) begin
    exp_ch[k].push_back(model_r3[k][7:0]);
  end
  if (rec.insn == MODEL_NOP_EXIT) begin
    exp_code[k].push_back(model_r3[k]);
    model_done[k] = 1'b1;
    if (model_r3[k] != '0) begin
      model_fail = 1'b1;
    end
  end
  if (rec.wben && rec.wbreg == MODEL_RET_REG) begin
    model_r3[k] = rec.wbdata;
  end
endfunction

function automatic bit model_all_done();
  bit all;
  all = 1'b1;
  for (int k = 0; k < NUM_CORES; k++) begin
    all = all && model_done[k];
  end
  return all;
endfunction

function automatic bit model_pending();
  bit busy;
  busy = 1'b0;
  for (int k = 0; k < NUM_CORES; k++) begin
    busy = busy || (exp_ch[k].size() != 0) || (exp_code[k].size() != 0);
  end
  return busy;
endfunction

`endif

//--- sim/tb_trace_hub.sv
`timescale 1ns/1ps

module tb_trace_hub;

  import trace_pkg::*;
  import mon_pkg::*;

  logic                       clk;
  logic                       rst;
  trace_rec_t [NUM_CORES-1:0] trace_in;
  logic                       putc_valid;
  char_evt_t                  putc_evt;
  logic                       exit_valid;
  exit_evt_t                  exit_evt;
  logic                       all_done;
  logic                       fail;
  logic                       overflow;

  logic [31:0] seed;
  int          errors;
  int          tests_run;
  int          tests_failed;
  bit          stream_chk;

  `include "trace_model.svh"

  trace_hub i_trace_hub (
    .clk          (clk),
    .rst_i        (rst),
    .trace_i      (trace_in),
    .putc_valid_o (putc_valid),
    .putc_o       (putc_evt),
    .exit_valid_o (exit_valid),
    .exit_o       (exit_evt),
    .all_done_o   (all_done),
    .fail_o       (fail),
    .overflow_o   (overflow)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  function automatic logic [31:0] lcg_next();
    seed = seed * 32'd1664525 + 32'd1013904223;
    return seed;
  endfunction

  task automatic report_mismatch(input string name, input logic [63:0] got,
                                 input logic [63:0] exp);
    $display("Fail at %0d ns: %s is %0h, expected %0h", $time, name, got, exp);
    errors++;
  endtask

  task automatic report_problem(input string msg);
    $display("Error at %0d ns: %s", $time, msg);
    errors++;
  endtask

  task automatic end_test(input string name, input int err_start);
    tests_run++;
    if (errors == err_start) begin
      $display("Test %s: passed", name);
    end else begin
      tests_failed++;
      $display("Test %s: failed with %0d errors", name, errors - err_start);
    end
  endtask

  // Match each output event against the oldest one owed by its core
  task automatic check_streams();
    int          c;
    logic [7:0]  ch;
    logic [31:0] code;
    if (putc_valid) begin
      c = int'(putc_evt.core_id);
      if (exp_ch[c].size() == 0) begin
        report_problem($sformatf("unexpected character from core %0d", c));
      end else begin
        ch = exp_ch[c].pop_front();
        if (putc_evt.ch !== ch) report_mismatch("putc_o.ch", 64'(putc_evt.ch), 64'(ch));
      end
    end
    if (exit_valid) begin
      c = int'(exit_evt.core_id);
      if (exp_code[c].size() == 0) begin
        report_problem($sformatf("unexpected exit event from core %0d", c));
      end else begin
        code = exp_code[c].pop_front();
        if (exit_evt.code !== code) report_mismatch("exit_o.code", 64'(exit_evt.code), 64'(code));
      end
    end
  endtask

  // One clock: check outputs at the falling edge, then drive the next records
  task automatic step(input trace_rec_t [NUM_CORES-1:0] recs);
    @(negedge clk);
    if (stream_chk) begin
      check_streams();
    end
    if (all_done && !model_all_done()) begin
      report_problem("all_done_o is high while a core is still running");
    end
    trace_in = recs;
    for (int k = 0; k < NUM_CORES; k++) begin
      model_apply(k, recs[k]);
    end
  endtask

  task automatic do_reset();
    @(negedge clk);
    rst      = 1'b1;
    trace_in = '0;
    model_reset();
    repeat (2) @(negedge clk);
    rst = 1'b0;
  endtask

  // Mix of ordinary work, writebacks, special no-ops and records with valid low
  function automatic trace_rec_t rand_rec(input bit allow_putc, input bit allow_exit);
    trace_rec_t  r;
    logic [31:0] sel;
    sel     = lcg_next();
    r.valid = (sel[1:0] != 2'b00);
    r.pc    = lcg_next() & ~32'h3;
    r.insn  = lcg_next();
    if (r.insn == MODEL_NOP_PUTC || r.insn == MODEL_NOP_EXIT) begin
      r.insn = 32'h0000_0013;
    end
    if (sel[6:4] == 3'd0 && (allow_putc || !r.valid)) begin
      r.insn = MODEL_NOP_PUTC;
    end else if (sel[6:4] == 3'd1 && (allow_exit || !r.valid)) begin
      r.insn = MODEL_NOP_EXIT;
    end
    r.wben   = sel[8];
    r.wbreg  = (sel[10:9] == 2'b00) ? MODEL_RET_REG : sel[15:11];
    r.wbdata = lcg_next();
    return r;
  endfunction

  // At most one valid putc per cycle across all cores
  task automatic rand_cycle(input bit allow_exit);
    trace_rec_t [NUM_CORES-1:0] recs;
    int                         putc_core;
    putc_core = int'(lcg_next() % (NUM_CORES + 1));
    for (int k = 0; k < NUM_CORES; k++) begin
      recs[k] = rand_rec(k == putc_core, allow_exit);
    end
    step(recs);
  endtask

  task automatic exit_core(input int k, input logic [31:0] code);
    trace_rec_t [NUM_CORES-1:0] recs;
    recs           = '0;
    recs[k].valid  = 1'b1;
    recs[k].insn   = 32'h0000_0013;
    recs[k].wben   = 1'b1;
    recs[k].wbreg  = MODEL_RET_REG;
    recs[k].wbdata = code;
    step(recs);
    recs          = '0;
    recs[k].valid = 1'b1;
    recs[k].insn  = MODEL_NOP_EXIT;
    step(recs);
  endtask

  task automatic check_outputs_low();
    if ({putc_valid, exit_valid, all_done, fail, overflow} !== 5'b0) begin
      report_mismatch("{putc_valid_o,exit_valid_o,all_done_o,fail_o,overflow_o}",
                      64'({putc_valid, exit_valid, all_done, fail, overflow}), 64'h0);
    end
    if (putc_evt !== '0) report_mismatch("putc_o", 64'(putc_evt), 64'h0);
    if (exit_evt !== '0) report_mismatch("exit_o", 64'(exit_evt), 64'h0);
  endtask

  task automatic test_reset();
    int start;
    start = errors;
    do_reset();
    check_outputs_low();
    step('0);
    check_outputs_low();
    end_test("outputs low after reset", start);
  endtask

  // Random traffic, then every core exits; bad_core gets a nonzero code
  task automatic run_session(input string name, input int bad_core);
    int          start;
    int          n;
    logic [31:0] code;
    start = errors;
    do_reset();
    for (int i = 0; i < 150; i++) begin
      rand_cycle(1'b0);
    end
    for (int k = 0; k < NUM_CORES; k++) begin
      code = (k == bad_core) ? (lcg_next() | 32'h1) : 32'h0;
      exit_core(k, code);
    end
    // Terminated cores must stay silent
    for (int i = 0; i < 20; i++) begin
      rand_cycle(1'b1);
    end
    n = 0;
    while (!all_done && n < 20) begin
      step('0);
      n++;
    end
    if (!all_done) report_problem("all_done_o did not rise after every core exited");
    if (fail !== model_fail) report_mismatch("fail_o", 64'(fail), 64'(model_fail));
    n = 0;
    while (model_pending() && n < 50) begin
      step('0);
      n++;
    end
    if (model_pending()) report_problem("expected events never appeared on the outputs");
    repeat (4) step('0);
    if (overflow !== 1'b0) report_mismatch("overflow_o", 64'(overflow), 64'h0);
    end_test(name, start);
  endtask

  task automatic test_overflow();
    int                         start;
    trace_rec_t [NUM_CORES-1:0] recs;
    start = errors;
    do_reset();
    stream_chk = 1'b0;
    recs       = '0;
    for (int k = 0; k < NUM_CORES; k++) begin
      recs[k].valid = 1'b1;
      recs[k].insn  = MODEL_NOP_PUTC;
    end
    if (overflow !== 1'b0) report_mismatch("overflow_o", 64'(overflow), 64'h0);
    repeat (8) step(recs);
    repeat (4) step('0);
    if (overflow !== 1'b1) report_mismatch("overflow_o", 64'(overflow), 64'h1);
    stream_chk = 1'b1;
    end_test("putc burst overflow", start);
  endtask

  initial begin
    rst          = 1'b1;
    trace_in     = '0;
    seed         = 32'h6e65;
    errors       = 0;
    tests_run    = 0;
    tests_failed = 0;
    stream_chk   = 1'b1;
    model_reset();
    test_reset();
    run_session("random traffic, all exit codes zero", -1);
    run_session("random traffic, one nonzero exit code", 2);
    test_overflow();
    $display("Summary: %0d tests, %0d failed, %0d errors", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule : tb_trace_hub

//--- files.f
+incdir+sim
verilog/trace_pkg.sv
verilog/mon_pkg.sv
verilog/core_trace_monitor.sv
verilog/event_merge.sv
verilog/done_tracker.sv
verilog/trace_hub.sv
sim/tb_trace_hub.sv

//--- Makefile
TOP = tb_trace_hub

.PHONY: all run lint clean

all: run

obj_dir/V$(TOP): files.f $(wildcard verilog/*.sv sim/*.sv sim/*.svh)
	verilator --binary --timing --assert -j 0 -Wno-fatal -f files.f --top-module $(TOP)

run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "TEST RESULT: PASS" sim.log

lint:
	verilator --lint-only -Wall --timing -f files.f --top-module $(TOP)

clean:
	rm -rf obj_dir sim.log
